// File: dv/tb_rv_alu_core.sv
module tb_rv_alu_core;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int queue_depth = 4;
    localparam int ret_credits = 2;
    localparam int num_insts   = 300;

    logic        clk = 1'b0;
    logic        arst_n_i;
    logic        inst_valid_i;
    logic [31:0] inst_i;
    logic [31:0] inst_addr_i;
    logic        inst_credit_o;
    logic        ret_credit_i;
    logic        ret_valid_o;
    logic [31:0] ret_addr_o;
    logic [4:0]  ret_rd_o;
    logic        ret_wen_o;
    logic [31:0] ret_data_o;

    // reference register model, stepped in send order
    logic [31:0] model_regs [32];
    logic [31:0] exp_addr [num_insts];
    logic [31:0] exp_data [num_insts];
    logic [4:0]  exp_rd [num_insts];
    logic        exp_wen [num_insts];

    int          sent_count   = 0;
    int          ret_count    = 0;
    int          send_credits = queue_depth;
    int          sink_credits = ret_credits;
    int          owed         = 0;
    int          hold         = 0;
    logic [31:0] send_rng     = 32'd19001;
    logic [31:0] sink_rng;

    rv_alu_core #(.QUEUE_DEPTH(queue_depth), .RET_CREDITS(ret_credits)) dut (
        .clk(clk), .arst_n_i(arst_n_i), .inst_valid_i(inst_valid_i), .inst_i(inst_i),
        .inst_addr_i(inst_addr_i), .inst_credit_o(inst_credit_o),
        .ret_credit_i(ret_credit_i), .ret_valid_o(ret_valid_o), .ret_addr_o(ret_addr_o),
        .ret_rd_o(ret_rd_o), .ret_wen_o(ret_wen_o), .ret_data_o(ret_data_o)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // ******************************
    // stimulus and reference model
    // ******************************

    // small register range so that neighbours depend on each other
    function automatic logic [31:0] make_inst(input logic [31:0] r, input logic [31:0] s);
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [6:0]  f7;
        logic [31:0] w;
        f3  = r[2:0];
        rd  = {2'b00, r[5:3]};
        rs1 = {2'b00, r[8:6]};
        rs2 = {2'b00, r[11:9]};
        f7  = ((f3 == 3'd0 || f3 == 3'd5) && r[12]) ? 7'h20 : 7'h00;
        if (r[16:13] == 4'd0) begin
            // unsupported opcode, rest of the word is noise
            w = {s[31:7], (s[6:0] == 7'h13 || s[6:0] == 7'h33) ? 7'h03 : s[6:0]};
        end else if (r[17]) begin
            w = {f7, rs2, rs1, f3, rd, 7'h33};
        end else if (f3 == 3'd1 || f3 == 3'd5) begin
            w = {f7, s[4:0], rs1, f3, rd, 7'h13};
        end else begin
            w = {s[11:0], rs1, f3, rd, 7'h13};
        end
        return w;
    endfunction

    task automatic model_step(input logic [31:0] w, input int k);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [4:0]  sh;
        a  = model_regs[w[19:15]];
        b  = (w[6:0] == 7'h33) ? model_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
        sh = b[4:0];
        case (w[14:12])
            3'd0: res = (w[6:0] == 7'h33 && w[30]) ? a - b : a + b;
            3'd1: res = a << sh;
            3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: res = (a < b) ? 32'd1 : 32'd0;
            3'd4: res = a ^ b;
            3'd5: begin
                // arithmetic form copies the sign bit
                if (w[30]) begin
                    res = $signed(a) >>> sh;
                end else begin
                    res = a >> sh;
                end
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        exp_addr[k] = 32'h0000_1000 + 32'(k) * 4;
        exp_wen[k]  = (w[6:0] == 7'h13) || (w[6:0] == 7'h33);
        exp_rd[k]   = w[11:7];
        exp_data[k] = res;
        if (exp_wen[k] && w[11:7] != 5'd0) begin
            model_regs[w[11:7]] = res;
        end
    endtask

    // sender spends a credit per valid cycle
    always @(posedge clk) begin
        logic [31:0] r;
        logic [31:0] s;
        if (arst_n_i) begin
            if (inst_credit_o) begin
                send_credits++;
            end
            r        = xorshift(send_rng);
            s        = xorshift(r);
            send_rng = s;
            if (sent_count < num_insts && send_credits > 0 && r[31:30] != 2'd0) begin
                inst_valid_i <= 1'b1;
                inst_i       <= make_inst(r, s);
                inst_addr_i  <= 32'h0000_1000 + 32'(sent_count) * 4;
                model_step(make_inst(r, s), sent_count);
                send_credits--;
                sent_count++;
            end else begin
                inst_valid_i <= 1'b0;
            end
        end
    end

    // sink returns owed credits late, sometimes not for a long while
    always @(posedge clk) begin
        if (arst_n_i) begin
            if (ret_valid_o) begin
                sink_credits--;
                owed++;
            end
            if (ret_credit_i) begin
                sink_credits++;
            end
            sink_rng = xorshift(sink_rng);
            if (hold > 0) begin
                hold--;
            end else if (sink_rng[5:0] == 6'd0) begin
                hold = 20 + int'(sink_rng[11:6] % 40);
            end
            if (hold == 0 && owed > 0 && sink_rng[13:12] != 2'd0) begin
                ret_credit_i <= 1'b1;
                owed--;
            end else begin
                ret_credit_i <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (arst_n_i && ret_valid_o) begin
            ret_count <= ret_count + 1;
        end
    end

    // ******************************
    // checks
    // ******************************

    task automatic report_fail(input string msg);
        $display("Fail %0t: %s", $time, msg);
        $display("RESULT: FAIL");
        $fatal(1, "check failed");
    endtask

    assert property (@(posedge clk) disable iff (!arst_n_i) ret_valid_o |-> ret_count < sent_count)
        else report_fail($sformatf("retire %0d with only %0d sent",
                                   $sampled(ret_count), $sampled(sent_count)));

    assert property (@(posedge clk) disable iff (!arst_n_i)
        ret_valid_o |-> (ret_addr_o == exp_addr[ret_count] && ret_wen_o == exp_wen[ret_count]))
        else report_fail($sformatf("retire %0d addr %h wen %b, expected addr %h wen %b",
                                   $sampled(ret_count), $sampled(ret_addr_o),
                                   $sampled(ret_wen_o), exp_addr[$sampled(ret_count)],
                                   exp_wen[$sampled(ret_count)]));

    assert property (@(posedge clk) disable iff (!arst_n_i)
        (ret_valid_o && exp_wen[ret_count]) |->
            (ret_rd_o == exp_rd[ret_count] && ret_data_o == exp_data[ret_count]))
        else report_fail($sformatf("retire %0d rd %0d data %h, expected rd %0d data %h",
                                   $sampled(ret_count), $sampled(ret_rd_o),
                                   $sampled(ret_data_o), exp_rd[$sampled(ret_count)],
                                   exp_data[$sampled(ret_count)]));

    assert property (@(posedge clk) disable iff (!arst_n_i) ret_valid_o |-> sink_credits > 0)
        else report_fail("retire valid while the sink holds no credit for the core");

    assert property (@(posedge clk) disable iff (!arst_n_i)
        send_credits >= 0 && send_credits <= queue_depth)
        else report_fail($sformatf("sender credits at %0d", $sampled(send_credits)));

    initial begin
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        // sink stream derived from the same seed
        sink_rng     = xorshift(~32'd19001);
        arst_n_i     = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        inst_addr_i  = '0;
        ret_credit_i = 1'b0;
        repeat (3) @(posedge clk);
        arst_n_i <= 1'b1;
        while (ret_count < num_insts) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        if (ret_count == sent_count && send_credits == queue_depth) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            report_fail("instructions lost or sender credits not returned at the end");
        end
    end

    // watchdog
    initial begin
        repeat (num_insts * 20 + 100) @(posedge clk);
        $display("watchdog expired with %0d of %0d instructions retired", ret_count, num_insts);
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    end

endmodule

// File: hdl/alu_execute.sv
module alu_execute (
    input  logic                               clk,
    input  logic                               arst_n_i,
    input  logic                               valid_i,
    input  logic [rv_core_pkg::xlen-1:0]       addr_i,
    input  rv_core_pkg::alu_op_e               op_i,
    input  logic [rv_core_pkg::xlen-1:0]       op1_i,
    input  logic [rv_core_pkg::xlen-1:0]       op2_i,
    input  logic                               wen_i,
    input  logic [rv_core_pkg::reg_addr_w-1:0] rd_i,
    input  logic                               stall_i,
    output logic                               valid_o,
    output logic [rv_core_pkg::xlen-1:0]       addr_o,
    output logic                               wen_o,
    output logic [rv_core_pkg::reg_addr_w-1:0] rd_o,
    output logic [rv_core_pkg::xlen-1:0]       data_o
);
    import rv_core_pkg::*;

    logic [4:0]      shamt;
    logic [xlen-1:0] result;

    // only the low five bits count as shift amount
    assign shamt = op2_i[4:0];

    always_comb begin
        case (op_i)
            alu_add:  result = op1_i + op2_i;
            alu_sub:  result = op1_i - op2_i;
            alu_sll:  result = op1_i << shamt;
            alu_slt:  result = {{(xlen - 1){1'b0}}, ($signed(op1_i) < $signed(op2_i))};
            alu_sltu: result = {{(xlen - 1){1'b0}}, (op1_i < op2_i)};
            alu_xor:  result = op1_i ^ op2_i;
            alu_srl:  result = op1_i >> shamt;
            alu_sra:  result = $signed(op1_i) >>> shamt;
            alu_or:   result = op1_i | op2_i;
            alu_and:  result = op1_i & op2_i;
            default:  result = '0;
        endcase
    end

    // execute/result stage register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
            wen_o   <= 1'b0;
        end else if (!stall_i) begin
            valid_o <= valid_i;
            wen_o   <= wen_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            addr_o <= addr_i;
            rd_o   <= rd_i;
            data_o <= result;
        end
    end

endmodule

// File: hdl/inst_decode.sv
module inst_decode (
    input  logic                               clk,
    input  logic                               arst_n_i,
    input  logic                               valid_i,
    input  rv_core_pkg::inst_u                 inst_i,
    input  logic [rv_core_pkg::xlen-1:0]       addr_i,
    input  logic                               stall_i,
    output logic                               pop_o,
    output logic [rv_core_pkg::reg_addr_w-1:0] rs1_addr_o,
    output logic [rv_core_pkg::reg_addr_w-1:0] rs2_addr_o,
    input  logic [rv_core_pkg::xlen-1:0]       rs1_data_i,
    input  logic [rv_core_pkg::xlen-1:0]       rs2_data_i,
    input  logic                               ex_wen_i,
    input  logic [rv_core_pkg::reg_addr_w-1:0] ex_rd_i,
    input  logic [rv_core_pkg::xlen-1:0]       ex_data_i,
    input  logic                               wb_wen_i,
    input  logic [rv_core_pkg::reg_addr_w-1:0] wb_rd_i,
    input  logic [rv_core_pkg::xlen-1:0]       wb_data_i,
    output logic                               valid_o,
    output logic [rv_core_pkg::xlen-1:0]       addr_o,
    output rv_core_pkg::alu_op_e               op_o,
    output logic [rv_core_pkg::xlen-1:0]       op1_o,
    output logic [rv_core_pkg::xlen-1:0]       op2_o,
    output logic                               wen_o,
    output logic [rv_core_pkg::reg_addr_w-1:0] rd_o
);
    import rv_core_pkg::*;

    alu_op_e         dec_op;
    logic            dec_wen;
    logic            use_rs1;
    logic            use_rs2;
    logic [xlen-1:0] imm_sext;
    logic [xlen-1:0] shamt_zext;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] dec_op2;
    logic            hazard;

    // ******************************
    // operand forwarding
    // ******************************

    // execute result wins over writeback, writeback over the register file
    function automatic logic [xlen-1:0] fwd_sel(input logic [reg_addr_w-1:0] src,
                                                input logic [xlen-1:0]       rf_val);
        logic [xlen-1:0] val;
        if (src == '0) begin
            val = '0;
        end else if (ex_wen_i && (ex_rd_i == src)) begin
            val = ex_data_i;
        end else if (wb_wen_i && (wb_rd_i == src)) begin
            val = wb_data_i;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    assign rs1_addr_o = inst_i.i_fmt.rs1;
    assign rs2_addr_o = inst_i.r_fmt.rs2;
    assign rs1_val    = fwd_sel(rs1_addr_o, rs1_data_i);
    assign rs2_val    = fwd_sel(rs2_addr_o, rs2_data_i);
    assign imm_sext   = {{(xlen - 12){inst_i.i_fmt.imm[11]}}, inst_i.i_fmt.imm};
    assign shamt_zext = {{(xlen - 5){1'b0}}, inst_i.i_fmt.imm[4:0]};

    // ******************************
    // opcode and function decode
    // ******************************

    always_comb begin
        dec_op  = alu_add;
        dec_wen = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        dec_op2 = '0;
        case (inst_i.i_fmt.opcode)
            op_imm: begin
                dec_wen = 1'b1;
                use_rs1 = 1'b1;
                dec_op2 = imm_sext;
                case (inst_i.i_fmt.funct3)
                    f3_add_sub: dec_op = alu_add;
                    f3_slt:     dec_op = alu_slt;
                    f3_sltu:    dec_op = alu_sltu;
                    f3_xor:     dec_op = alu_xor;
                    f3_or:      dec_op = alu_or;
                    f3_and:     dec_op = alu_and;
                    f3_sll: begin
                        dec_op  = alu_sll;
                        dec_op2 = shamt_zext;
                    end
                    default: begin
                        // srli or srai, told apart by the upper immediate bits
                        dec_op2 = shamt_zext;
                        if (inst_i.i_fmt.imm[11:5] == funct7_alt) begin
                            dec_op = alu_sra;
                        end else begin
                            dec_op = alu_srl;
                        end
                    end
                endcase
            end
            op_reg: begin
                if ((inst_i.r_fmt.funct7 == '0) || (inst_i.r_fmt.funct7 == funct7_alt)) begin
                    dec_wen = 1'b1;
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                    dec_op2 = rs2_val;
                    case (inst_i.r_fmt.funct3)
                        f3_sll:  dec_op = alu_sll;
                        f3_slt:  dec_op = alu_slt;
                        f3_sltu: dec_op = alu_sltu;
                        f3_xor:  dec_op = alu_xor;
                        f3_or:   dec_op = alu_or;
                        f3_and:  dec_op = alu_and;
                        f3_add_sub: begin
                            dec_op = (inst_i.r_fmt.funct7 == funct7_alt) ? alu_sub : alu_add;
                        end
                        default: begin
                            dec_op = (inst_i.r_fmt.funct7 == funct7_alt) ? alu_sra : alu_srl;
                        end
                    endcase
                end
            end
            default: begin
                // unsupported word, retired later as a bubble
                dec_wen = 1'b0;
            end
        endcase
    end

    // the producer one ahead has no result yet, so hold the word for a cycle
    assign hazard = wen_o && (rd_o != '0) &&
                    ((use_rs1 && (rs1_addr_o == rd_o)) || (use_rs2 && (rs2_addr_o == rd_o)));
    assign pop_o  = valid_i && !stall_i && !hazard;

    // ******************************
    // decode/execute stage register
    // ******************************

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
            wen_o   <= 1'b0;
        end else if (!stall_i) begin
            valid_o <= pop_o;
            wen_o   <= pop_o && dec_wen;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            addr_o <= addr_i;
            op_o   <= dec_op;
            op1_o  <= use_rs1 ? rs1_val : '0;
            op2_o  <= dec_op2;
            rd_o   <= inst_i.i_fmt.rd;
        end
    end

    // a queued word waits at the head until decode takes it
    assert property (@(posedge clk) disable iff (!arst_n_i)
        (valid_i && !pop_o) |=> (valid_i && $stable(inst_i) && $stable(addr_i)))
        else $error("queue head changed before decode took it");

endmodule

// File: hdl/inst_queue.sv
module inst_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                         clk,
    input  logic                         arst_n_i,
    input  logic                         push_i,
    input  rv_core_pkg::inst_u           inst_i,
    input  logic [rv_core_pkg::xlen-1:0] addr_i,
    input  logic                         pop_i,
    output logic                         valid_o,
    output rv_core_pkg::inst_u           inst_o,
    output logic [rv_core_pkg::xlen-1:0] addr_o
);
    import rv_core_pkg::*;

    localparam int ptr_w = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int cnt_w = $clog2(QUEUE_DEPTH + 1);

    inst_u            inst_mem [QUEUE_DEPTH];
    logic [xlen-1:0]  addr_mem [QUEUE_DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == cnt_w'(QUEUE_DEPTH));
    assign valid_o = (count != '0);
    assign do_push = push_i && !full;
    assign do_pop  = pop_i && valid_o;
    assign inst_o  = inst_mem[rd_ptr];
    assign addr_o  = addr_mem[rd_ptr];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            inst_mem[wr_ptr] <= inst_i;
            addr_mem[wr_ptr] <= addr_i;
        end
    end

    // sender credits must keep the queue from overflowing
    assert property (@(posedge clk) disable iff (!arst_n_i) full |-> !push_i)
        else $error("push into a full instruction queue");

    // decode only pops an entry it has seen
    assert property (@(posedge clk) disable iff (!arst_n_i) pop_i |-> valid_o)
        else $error("pop from an empty instruction queue");

endmodule

// File: hdl/reg_file.sv
module reg_file (
    input  logic                               clk,
    input  logic                               arst_n_i,
    input  logic [rv_core_pkg::reg_addr_w-1:0] rs1_addr_i,
    input  logic [rv_core_pkg::reg_addr_w-1:0] rs2_addr_i,
    output logic [rv_core_pkg::xlen-1:0]       rs1_data_o,
    output logic [rv_core_pkg::xlen-1:0]       rs2_data_o,
    input  logic                               wen_i,
    input  logic [rv_core_pkg::reg_addr_w-1:0] rd_i,
    input  logic [rv_core_pkg::xlen-1:0]       wdata_i
);
    import rv_core_pkg::*;

    localparam int num_regs = 1 << reg_addr_w;

    logic [xlen-1:0] regs [num_regs];

    // x0 reads as zero whatever the array holds
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && (rd_i != '0)) begin
            regs[rd_i] <= wdata_i;
        end
    end

endmodule

// File: hdl/result_writeback.sv
module result_writeback #(
    parameter int RET_CREDITS = 2
) (
    input  logic                               clk,
    input  logic                               arst_n_i,
    input  logic                               valid_i,
    input  logic [rv_core_pkg::xlen-1:0]       addr_i,
    input  logic                               wen_i,
    input  logic [rv_core_pkg::reg_addr_w-1:0] rd_i,
    input  logic [rv_core_pkg::xlen-1:0]       data_i,
    input  logic                               ret_credit_i,
    output logic                               stall_o,
    output logic                               rf_wen_o,
    output logic [rv_core_pkg::reg_addr_w-1:0] rf_rd_o,
    output logic [rv_core_pkg::xlen-1:0]       rf_data_o,
    output logic                               ret_valid_o,
    output logic [rv_core_pkg::xlen-1:0]       ret_addr_o,
    output logic [rv_core_pkg::reg_addr_w-1:0] ret_rd_o,
    output logic                               ret_wen_o,
    output logic [rv_core_pkg::xlen-1:0]       ret_data_o
);

    localparam int cnt_w = $clog2(RET_CREDITS + 1);

    logic [cnt_w-1:0] credit_cnt;
    logic             retire;

    // retire needs a sink credit, otherwise the whole pipe waits
    assign retire  = valid_i && (credit_cnt != '0);
    assign stall_o = valid_i && (credit_cnt == '0);

    assign ret_valid_o = retire;
    assign ret_addr_o  = addr_i;
    assign ret_rd_o    = rd_i;
    assign ret_wen_o   = wen_i;
    assign ret_data_o  = data_i;

    // register file write lands at the next edge
    assign rf_wen_o  = retire && wen_i;
    assign rf_rd_o   = rd_i;
    assign rf_data_o = data_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credit_cnt <= cnt_w'(RET_CREDITS);
        end else begin
            credit_cnt <= credit_cnt - cnt_w'(retire) + cnt_w'(ret_credit_i);
        end
    end

    // the sink may only return what was spent
    assert property (@(posedge clk) disable iff (!arst_n_i) credit_cnt <= RET_CREDITS)
        else $error("retire credit count above its initial value");

endmodule

// File: hdl/rv_alu_core.sv
module rv_alu_core #(
    parameter int QUEUE_DEPTH = 4,
    parameter int RET_CREDITS = 2
) (
    input  logic                               clk,
    input  logic                               arst_n_i,
    input  logic                               inst_valid_i,
    input  rv_core_pkg::inst_u                 inst_i,
    input  logic [rv_core_pkg::xlen-1:0]       inst_addr_i,
    output logic                               inst_credit_o,
    input  logic                               ret_credit_i,
    output logic                               ret_valid_o,
    output logic [rv_core_pkg::xlen-1:0]       ret_addr_o,
    output logic [rv_core_pkg::reg_addr_w-1:0] ret_rd_o,
    output logic                               ret_wen_o,
    output logic [rv_core_pkg::xlen-1:0]       ret_data_o
);
    import rv_core_pkg::*;

    // ******************************
    // stage interconnect
    // ******************************

    logic                  q_valid;
    inst_u                 q_inst;
    logic [xlen-1:0]       q_addr;
    logic                  q_pop;
    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;
    logic                  id_valid;
    logic [xlen-1:0]       id_addr;
    alu_op_e               id_op;
    logic [xlen-1:0]       id_op1;
    logic [xlen-1:0]       id_op2;
    logic                  id_wen;
    logic [reg_addr_w-1:0] id_rd;
    logic                  ex_valid;
    logic [xlen-1:0]       ex_addr;
    logic                  ex_wen;
    logic [reg_addr_w-1:0] ex_rd;
    logic [xlen-1:0]       ex_data;
    logic                  wb_wen;
    logic [reg_addr_w-1:0] wb_rd;
    logic [xlen-1:0]       wb_data;
    logic                  stall;

    // each pop frees one queue slot for the sender
    assign inst_credit_o = q_pop;

    inst_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
        .clk(clk), .arst_n_i(arst_n_i), .push_i(inst_valid_i), .inst_i(inst_i),
        .addr_i(inst_addr_i), .pop_i(q_pop), .valid_o(q_valid), .inst_o(q_inst),
        .addr_o(q_addr)
    );

    reg_file u_regs (
        .clk(clk), .arst_n_i(arst_n_i), .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data), .wen_i(wb_wen), .rd_i(wb_rd),
        .wdata_i(wb_data)
    );

    inst_decode u_decode (
        .clk(clk), .arst_n_i(arst_n_i), .valid_i(q_valid), .inst_i(q_inst), .addr_i(q_addr),
        .stall_i(stall), .pop_o(q_pop), .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .ex_wen_i(ex_wen), .ex_rd_i(ex_rd), .ex_data_i(ex_data),
        .wb_wen_i(wb_wen), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
        .valid_o(id_valid), .addr_o(id_addr), .op_o(id_op), .op1_o(id_op1),
        .op2_o(id_op2), .wen_o(id_wen), .rd_o(id_rd)
    );

    alu_execute u_execute (
        .clk(clk), .arst_n_i(arst_n_i), .valid_i(id_valid), .addr_i(id_addr), .op_i(id_op),
        .op1_i(id_op1), .op2_i(id_op2), .wen_i(id_wen), .rd_i(id_rd), .stall_i(stall),
        .valid_o(ex_valid), .addr_o(ex_addr), .wen_o(ex_wen), .rd_o(ex_rd), .data_o(ex_data)
    );

    result_writeback #(.RET_CREDITS(RET_CREDITS)) u_writeback (
        .clk(clk), .arst_n_i(arst_n_i), .valid_i(ex_valid), .addr_i(ex_addr),
        .wen_i(ex_wen), .rd_i(ex_rd), .data_i(ex_data), .ret_credit_i(ret_credit_i),
        .stall_o(stall), .rf_wen_o(wb_wen), .rf_rd_o(wb_rd), .rf_data_o(wb_data),
        .ret_valid_o(ret_valid_o), .ret_addr_o(ret_addr_o), .ret_rd_o(ret_rd_o),
        .ret_wen_o(ret_wen_o), .ret_data_o(ret_data_o)
    );

endmodule

// File: hdl/rv_core_pkg.sv
package rv_core_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // opcodes of the two supported groups
    localparam logic [6:0] op_imm = 7'b0010011;
    localparam logic [6:0] op_reg = 7'b0110011;

    // funct3 selections, shared by both groups
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // selects sub, sra and srai
    localparam logic [6:0] funct7_alt = 7'b0100000;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    // one instruction word, two field layouts
    typedef union packed {
        struct packed {
            logic [11:0]           imm;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } i_fmt;
        struct packed {
            logic [6:0]            funct7;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } r_fmt;
    } inst_u;

endpackage

// File: list.f
hdl/rv_core_pkg.sv
hdl/inst_queue.sv
hdl/reg_file.sv
hdl/inst_decode.sv
hdl/alu_execute.sv
hdl/result_writeback.sv
hdl/rv_alu_core.sv
dv/tb_rv_alu_core.sv
